// ==== common/ooo_settings.svh ====
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

// Multiply reservation station entries.
`define RS_DEPTH 8

// Edges from issue_valid to the completion queue.
`define MUL_LATENCY 3

// Completion queue entries, a power of two.
`define MUL_QUEUE_DEPTH 4

// Physical register tag width.
`define TAG_W 8

// Program counter width.
`define PC_W 32

`endif

// ==== common/ooo_types_pkg.sv ====
`include "ooo_settings.svh"

package ooo_types_pkg;

  // Physical register tag as renamed at dispatch.
  typedef logic [`TAG_W-1:0] phys_tag_t;

  // Instruction PC, carried for tracing only.
  typedef logic [`PC_W-1:0] pc_t;

  // Index of one reservation station entry.
  typedef logic [$clog2(`RS_DEPTH)-1:0] rs_idx_t;

endpackage

// ==== common/cdb_pkg.sv ====
package cdb_pkg;

  // Number of producers sharing the common data bus.
  localparam int CDB_NUM_SRC = 3;

  // Encoding doubles as the bit position in request and grant vectors.
  typedef enum logic [1:0] {
    SRC_MUL = 2'd0,
    SRC_ALU = 2'd1,
    SRC_LD  = 2'd2
  } cdb_src_t;

  // One bit per producer, indexed by cdb_src_t.
  typedef logic [CDB_NUM_SRC-1:0] cdb_vec_t;

endpackage

// ==== rs_mul/rs_mul_station.sv ====
`timescale 1ns/1ps
`include "ooo_settings.svh"

module rs_mul_station (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     flush,
  input  logic                     dispatch_valid,
  input  ooo_types_pkg::pc_t       dispatch_pc,
  input  ooo_types_pkg::phys_tag_t dispatch_rd,
  input  ooo_types_pkg::phys_tag_t dispatch_src1,
  input  ooo_types_pkg::phys_tag_t dispatch_src2,
  input  logic                     src1_ready,
  input  logic                     src2_ready,
  input  logic                     cdb_valid,
  input  ooo_types_pkg::phys_tag_t cdb_tag,
  input  logic                     mul_stall,
  output logic                     rs_full,
  output logic                     issue_valid,
  output ooo_types_pkg::pc_t       issue_pc,
  output ooo_types_pkg::phys_tag_t issue_rd,
  output ooo_types_pkg::phys_tag_t issue_src1,
  output ooo_types_pkg::phys_tag_t issue_src2
);
  import ooo_types_pkg::*;

  // Entry state.
  logic [`RS_DEPTH-1:0] busy_q;
  logic [`RS_DEPTH-1:0] rdy1_q;
  logic [`RS_DEPTH-1:0] rdy2_q;
  pc_t                  pc_q   [`RS_DEPTH];
  phys_tag_t            rd_q   [`RS_DEPTH];
  phys_tag_t            src1_q [`RS_DEPTH];
  phys_tag_t            src2_q [`RS_DEPTH];

  logic [`RS_DEPTH-1:0] ready_vec;
  rs_idx_t              alloc_idx;
  rs_idx_t              sel_idx;
  logic                 sel_hit;
  logic                 do_alloc;
  logic                 do_issue;
  logic                 disp_rdy1;
  logic                 disp_rdy2;

  assign rs_full   = &busy_q;
  assign ready_vec = busy_q & rdy1_q & rdy2_q;

  // A tag on the bus in the dispatch cycle counts as already produced.
  assign disp_rdy1 = src1_ready || (cdb_valid && (dispatch_src1 == cdb_tag));
  assign disp_rdy2 = src2_ready || (cdb_valid && (dispatch_src2 == cdb_tag));

  assign do_alloc = dispatch_valid && !rs_full;
  assign do_issue = sel_hit && !mul_stall;

  // Scan from the top so the lowest index wins in both searches.
  always_comb begin
    alloc_idx = '0;
    sel_idx   = '0;
    sel_hit   = 1'b0;
    for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
      if (!busy_q[i]) begin
        alloc_idx = rs_idx_t'(i);
      end
      if (ready_vec[i]) begin
        sel_idx = rs_idx_t'(i);
        sel_hit = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q      <= '0;
      rdy1_q      <= '0;
      rdy2_q      <= '0;
      issue_valid <= 1'b0;
    end else if (flush) begin
      busy_q      <= '0;
      issue_valid <= 1'b0;
    end else begin
      // Wakeup of waiting operands.
      for (int i = 0; i < `RS_DEPTH; i++) begin
        if (cdb_valid && busy_q[i] && (src1_q[i] == cdb_tag)) begin
          rdy1_q[i] <= 1'b1;
        end
        if (cdb_valid && busy_q[i] && (src2_q[i] == cdb_tag)) begin
          rdy2_q[i] <= 1'b1;
        end
      end
      // The issued entry is still busy here, so it never equals alloc_idx.
      if (do_issue) begin
        busy_q[sel_idx] <= 1'b0;
      end
      if (do_alloc) begin
        busy_q[alloc_idx] <= 1'b1;
        rdy1_q[alloc_idx] <= disp_rdy1;
        rdy2_q[alloc_idx] <= disp_rdy2;
      end
      issue_valid <= do_issue;
    end
  end

  always_ff @(posedge clk) begin
    if (do_alloc) begin
      pc_q[alloc_idx]   <= dispatch_pc;
      rd_q[alloc_idx]   <= dispatch_rd;
      src1_q[alloc_idx] <= dispatch_src1;
      src2_q[alloc_idx] <= dispatch_src2;
    end
    if (do_issue) begin
      issue_pc   <= pc_q[sel_idx];
      issue_rd   <= rd_q[sel_idx];
      issue_src1 <= src1_q[sel_idx];
      issue_src2 <= src2_q[sel_idx];
    end
  end

endmodule

// ==== rs_mul/mul_pipe.sv ====
`timescale 1ns/1ps
`include "ooo_settings.svh"

module mul_pipe (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     flush,
  input  logic                     issue_valid,
  input  ooo_types_pkg::phys_tag_t issue_rd,
  input  logic                     mul_gnt,
  output logic                     mul_req,
  output ooo_types_pkg::phys_tag_t mul_tag,
  output logic                     mul_stall
);
  import ooo_types_pkg::*;

  // The issue cycle is the first stage, the registers hold the rest.
  localparam int STAGES = `MUL_LATENCY - 1;
  localparam int PTR_W  = $clog2(`MUL_QUEUE_DEPTH);
  localparam int CNT_W  = $clog2(`MUL_QUEUE_DEPTH + `MUL_LATENCY + 1);

  logic [STAGES-1:0] stage_v_q;
  phys_tag_t         stage_tag_q [STAGES];
  phys_tag_t         queue_q     [`MUL_QUEUE_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [PTR_W:0]    count_q;
  logic [CNT_W-1:0]  pending;
  logic              push;
  logic              pop;

  assign push    = stage_v_q[STAGES-1];
  assign mul_req = (count_q != '0);
  assign pop     = mul_gnt && mul_req;
  assign mul_tag = queue_q[rd_ptr_q];

  // Everything that may still land in the queue, including this cycle's issue.
  assign pending = CNT_W'(count_q) + CNT_W'($countones(stage_v_q)) + CNT_W'(issue_valid);
  assign mul_stall = (pending >= CNT_W'(`MUL_QUEUE_DEPTH));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_v_q <= '0;
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
    end else if (flush) begin
      stage_v_q <= '0;
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
    end else begin
      stage_v_q[0] <= issue_valid;
      for (int s = 1; s < STAGES; s++) begin
        stage_v_q[s] <= stage_v_q[s-1];
      end
      // Power-of-two depth, pointers wrap by overflow.
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
    end
  end

  always_ff @(posedge clk) begin
    stage_tag_q[0] <= issue_rd;
    for (int s = 1; s < STAGES; s++) begin
      stage_tag_q[s] <= stage_tag_q[s-1];
    end
    if (push) begin
      queue_q[wr_ptr_q] <= stage_tag_q[STAGES-1];
    end
  end

endmodule

// ==== hdl/cdb_arbiter.sv ====
`timescale 1ns/1ps

module cdb_arbiter (
  input  logic                     clk,
  input  logic                     rst_n,
  input  cdb_pkg::cdb_vec_t        req,
  input  ooo_types_pkg::phys_tag_t mul_tag,
  input  ooo_types_pkg::phys_tag_t alu_tag,
  input  ooo_types_pkg::phys_tag_t ld_tag,
  output cdb_pkg::cdb_vec_t        gnt,
  output logic                     cdb_valid,
  output ooo_types_pkg::phys_tag_t cdb_tag,
  output cdb_pkg::cdb_src_t        cdb_src
);
  import cdb_pkg::*;

  cdb_src_t last_q;
  cdb_src_t win;
  int       idx;

  // Priority starts at the source after the last winner.
  always_comb begin
    gnt = '0;
    win = last_q;
    for (int i = 1; i <= CDB_NUM_SRC; i++) begin
      idx = (int'(last_q) + i) % CDB_NUM_SRC;
      if (req[idx] && (gnt == '0)) begin
        gnt[idx] = 1'b1;
        win      = cdb_src_t'(idx);
      end
    end
  end

  assign cdb_valid = |gnt;
  assign cdb_src   = win;

  always_comb begin
    case (win)
      SRC_ALU: cdb_tag = alu_tag;
      SRC_LD:  cdb_tag = ld_tag;
      default: cdb_tag = mul_tag;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_q <= SRC_LD;
    end else if (cdb_valid) begin
      last_q <= win;
    end
  end

endmodule

// ==== hdl/mul_cluster_top.sv ====
`timescale 1ns/1ps

module mul_cluster_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     flush,
  input  logic                     dispatch_valid,
  input  ooo_types_pkg::pc_t       dispatch_pc,
  input  ooo_types_pkg::phys_tag_t dispatch_rd,
  input  ooo_types_pkg::phys_tag_t dispatch_src1,
  input  ooo_types_pkg::phys_tag_t dispatch_src2,
  input  logic                     src1_ready,
  input  logic                     src2_ready,
  output logic                     rs_full,
  output logic                     issue_valid,
  output ooo_types_pkg::pc_t       issue_pc,
  output ooo_types_pkg::phys_tag_t issue_rd,
  input  logic                     alu_req,
  input  ooo_types_pkg::phys_tag_t alu_tag,
  output logic                     alu_gnt,
  input  logic                     ld_req,
  input  ooo_types_pkg::phys_tag_t ld_tag,
  output logic                     ld_gnt,
  output logic                     cdb_valid,
  output ooo_types_pkg::phys_tag_t cdb_tag,
  output cdb_pkg::cdb_src_t        cdb_src
);
  import ooo_types_pkg::*;
  import cdb_pkg::*;

  cdb_vec_t  req;
  cdb_vec_t  gnt;
  logic      mul_req;
  phys_tag_t mul_tag;
  logic      mul_stall;

  assign req[SRC_MUL] = mul_req;
  assign req[SRC_ALU] = alu_req;
  assign req[SRC_LD]  = ld_req;
  assign alu_gnt      = gnt[SRC_ALU];
  assign ld_gnt       = gnt[SRC_LD];

  // Source tags leave the station for the operand read, not modelled here.
  rs_mul_station station_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush          (flush),
    .dispatch_valid (dispatch_valid),
    .dispatch_pc    (dispatch_pc),
    .dispatch_rd    (dispatch_rd),
    .dispatch_src1  (dispatch_src1),
    .dispatch_src2  (dispatch_src2),
    .src1_ready     (src1_ready),
    .src2_ready     (src2_ready),
    .cdb_valid      (cdb_valid),
    .cdb_tag        (cdb_tag),
    .mul_stall      (mul_stall),
    .rs_full        (rs_full),
    .issue_valid    (issue_valid),
    .issue_pc       (issue_pc),
    .issue_rd       (issue_rd),
    .issue_src1     (),
    .issue_src2     ()
  );

  mul_pipe pipe_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .issue_valid (issue_valid),
    .issue_rd    (issue_rd),
    .mul_gnt     (gnt[SRC_MUL]),
    .mul_req     (mul_req),
    .mul_tag     (mul_tag),
    .mul_stall   (mul_stall)
  );

  cdb_arbiter arbiter_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .mul_tag   (mul_tag),
    .alu_tag   (alu_tag),
    .ld_tag    (ld_tag),
    .gnt       (gnt),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag),
    .cdb_src   (cdb_src)
  );

endmodule

// ==== tb/mul_cluster_chk.sv ====
`timescale 1ns/1ps

module mul_cluster_chk (
  input logic              clk,
  input logic              rst_n,
  input logic              flush,
  input cdb_pkg::cdb_vec_t req,
  input cdb_pkg::cdb_vec_t gnt,
  input logic              cdb_valid,
  input logic              issue_valid,
  input logic              mul_stall,
  input logic              rs_full
);

  // At most one producer owns the bus.
  gnt_onehot_a: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(gnt))
    else $error("more than one CDB grant is high");

  bus_has_req_a: assert property (@(posedge clk) disable iff (!rst_n)
    cdb_valid |-> ((gnt & req) != '0))
    else $error("CDB valid without a granted request");

  // A stalled pipeline accepts no new issue at the next edge.
  stall_blocks_issue_a: assert property (@(posedge clk) disable iff (!rst_n)
    mul_stall |=> !issue_valid)
    else $error("issue registered while the pipeline stalled");

  flush_clears_a: assert property (@(posedge clk) disable iff (!rst_n)
    flush |=> (!rs_full && !issue_valid))
    else $error("station not empty after flush");

endmodule

bind mul_cluster_top mul_cluster_chk chk_i (
  .clk         (clk),
  .rst_n       (rst_n),
  .flush       (flush),
  .req         (req),
  .gnt         (gnt),
  .cdb_valid   (cdb_valid),
  .issue_valid (issue_valid),
  .mul_stall   (mul_stall),
  .rs_full     (rs_full)
);

// ==== tb/mul_cluster_tb.sv ====
`timescale 1ns/1ps
`include "ooo_settings.svh"

module mul_cluster_tb;
  import ooo_types_pkg::*;
  import cdb_pkg::*;

  localparam int NUM_TESTS = 7;

  logic clk = 1'b0;
  logic rst_n, flush, dispatch_valid, src1_ready, src2_ready;
  pc_t dispatch_pc, issue_pc;
  phys_tag_t dispatch_rd, dispatch_src1, dispatch_src2, issue_rd, alu_tag, ld_tag, cdb_tag;
  logic rs_full, issue_valid, alu_req, alu_gnt, ld_req, ld_gnt, cdb_valid;
  cdb_src_t cdb_src;

  phys_tag_t exp_rd_q[$];
  pc_t       exp_pc_q[$];
  phys_tag_t exp_mul_q[$];
  int        ext_seen[256];
  cdb_src_t  ext_src[256];
  int        errors = 0;
  int        issue_count = 0;
  int        bcast_count = 0;
  int        tri_cycles = 0;
  logic [31:0] rng = 32'h7c15;
  cdb_src_t  model_last;

  mul_cluster_top dut_i (.*);

  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // Destination tags stay below 8'h80, away from the wakeup tags.
  function automatic phys_tag_t next_tag();
    rng = xorshift32(rng);
    return {1'b0, rng[6:0]};
  endfunction

  // Priority order after each possible last winner.
  function automatic cdb_src_t rr_pick(input cdb_src_t last, input logic m, a, l);
    case (last)
      SRC_MUL: return a ? SRC_ALU : (l ? SRC_LD : SRC_MUL);
      SRC_ALU: return l ? SRC_LD : (m ? SRC_MUL : SRC_ALU);
      default: return m ? SRC_MUL : (a ? SRC_ALU : SRC_LD);
    endcase
  endfunction

  task automatic check_tag(input phys_tag_t got, input phys_tag_t exp, input string msg);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got %h expected %h", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic check_pc(input pc_t got, input pc_t exp, input string msg);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got %h expected %h", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic check_src(input cdb_src_t got, input cdb_src_t exp, input string msg);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got %s expected %s", $time, msg, got.name(), exp.name());
      errors++;
    end
  endtask

  task automatic fail_msg(input string msg);
    $display("Failure at %0t: %s", $time, msg);
    errors++;
  endtask

  // Outputs are sampled mid-cycle, where they are settled.
  always @(negedge clk) begin
    logic m;
    if (!rst_n) begin
      model_last = SRC_LD;
    end else begin
      m = dut_i.mul_req;
      if (m && alu_req && ld_req) tri_cycles++;
      if (cdb_valid !== (m | alu_req | ld_req)) fail_msg("CDB valid does not follow the requests");
      if (cdb_valid) begin
        check_src(cdb_src, rr_pick(model_last, m, alu_req, ld_req), "round-robin winner");
        model_last = rr_pick(model_last, m, alu_req, ld_req);
        bcast_count++;
        if (cdb_src == SRC_MUL) begin
          if (exp_mul_q.size() == 0) fail_msg($sformatf("MUL broadcast of %h unexpected", cdb_tag));
          else check_tag(cdb_tag, exp_mul_q.pop_front(), "MUL broadcast tag");
        end else begin
          ext_seen[cdb_tag]++;
          ext_src[cdb_tag] = cdb_src;
        end
      end
      if (issue_valid) begin
        issue_count++;
        if (exp_rd_q.size() == 0) begin
          fail_msg($sformatf("issue of %h unexpected", issue_rd));
        end else begin
          check_tag(issue_rd, exp_rd_q.pop_front(), "issue_rd");
          check_pc(issue_pc, exp_pc_q.pop_front(), "issue_pc");
        end
      end
    end
  end

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic expect_op(input pc_t pc, input phys_tag_t rd);
    exp_pc_q.push_back(pc);
    exp_rd_q.push_back(rd);
    exp_mul_q.push_back(rd);
  endtask

  task automatic dispatch_op(input pc_t pc, input phys_tag_t rd, input phys_tag_t s1,
                             input logic r1, input phys_tag_t s2, input logic r2);
    dispatch_valid = 1'b1;
    dispatch_pc    = pc;
    dispatch_rd    = rd;
    dispatch_src1  = s1;
    src1_ready     = r1;
    dispatch_src2  = s2;
    src2_ready     = r2;
    @(posedge clk);
    #2;
    dispatch_valid = 1'b0;
    src1_ready     = 1'b0;
    src2_ready     = 1'b0;
  endtask

  task automatic alu_send(input phys_tag_t tag);
    int waited;
    alu_req = 1'b1;
    alu_tag = tag;
    waited  = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!alu_gnt && waited < 50);
    if (waited > 3) fail_msg($sformatf("ALU request waited %0d cycles", waited));
    @(posedge clk);
    #2;
    alu_req = 1'b0;
  endtask

  task automatic ld_send(input phys_tag_t tag);
    int waited;
    ld_req = 1'b1;
    ld_tag = tag;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!ld_gnt && waited < 50);
    if (waited > 3) fail_msg($sformatf("load request waited %0d cycles", waited));
    @(posedge clk);
    #2;
    ld_req = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((exp_rd_q.size() != 0 || exp_mul_q.size() != 0) && n < 150) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (n >= 150) fail_msg("timed out waiting for issues and broadcasts");
  endtask

  task automatic check_ext(input phys_tag_t tag, input cdb_src_t src);
    if (ext_seen[tag] != 1) fail_msg($sformatf("tag %h broadcast %0d times", tag, ext_seen[tag]));
    else check_src(ext_src[tag], src, "external broadcast source");
  endtask

  task automatic test_ready_order();
    phys_tag_t rd;
    for (int i = 0; i < 3; i++) begin
      rd = next_tag();
      expect_op(32'h100 + 32'(4 * i), rd);
      dispatch_op(32'h100 + 32'(4 * i), rd, 8'h01, 1'b1, 8'h02, 1'b1);
    end
    wait_drain();
  endtask

  task automatic test_wakeup();
    phys_tag_t rd;
    int cnt;
    rd  = next_tag();
    cnt = issue_count;
    dispatch_op(32'h1000, rd, 8'hc1, 1'b0, 8'h02, 1'b1);
    idle(10);
    if (issue_count != cnt) fail_msg("entry issued before its operand was broadcast");
    expect_op(32'h1000, rd);
    alu_send(8'hc1);
    wait_drain();
    check_ext(8'hc1, SRC_ALU);
  endtask

  task automatic test_bypass();
    phys_tag_t rd;
    rd = next_tag();
    expect_op(32'h1800, rd);
    fork
      alu_send(8'hc2);
      dispatch_op(32'h1800, rd, 8'hc2, 1'b0, 8'h03, 1'b1);
    join
    wait_drain();
    check_ext(8'hc2, SRC_ALU);
  endtask

  task automatic test_full();
    phys_tag_t rds[`RS_DEPTH];
    int cnt;
    cnt = issue_count;
    for (int i = 0; i < `RS_DEPTH; i++) begin
      rds[i] = next_tag();
      dispatch_op(32'h2000 + 32'(4 * i), rds[i], 8'hc3, 1'b0, 8'h04, 1'b1);
    end
    if (rs_full !== 1'b1) fail_msg("rs_full is not set with every entry busy");
    dispatch_op(32'h2ffc, next_tag(), 8'h05, 1'b1, 8'h06, 1'b1);
    idle(5);
    if (issue_count != cnt) fail_msg("an entry issued while its operand was pending");
    for (int i = 0; i < `RS_DEPTH; i++) expect_op(32'h2000 + 32'(4 * i), rds[i]);
    alu_send(8'hc3);
    wait_drain();
    idle(10);
  endtask

  task automatic test_round_robin();
    phys_tag_t rd;
    for (int i = 0; i < 3; i++) begin
      rd = next_tag();
      expect_op(32'h3000 + 32'(4 * i), rd);
      dispatch_op(32'h3000 + 32'(4 * i), rd, 8'h07, 1'b1, 8'h08, 1'b1);
    end
    fork
      for (int i = 0; i < 4; i++) alu_send(8'h80 + 8'(i));
      for (int i = 0; i < 4; i++) ld_send(8'ha0 + 8'(i));
    join
    wait_drain();
    if (tri_cycles == 0) fail_msg("no cycle had all three requesters active");
    for (int i = 0; i < 4; i++) begin
      check_ext(8'h80 + 8'(i), SRC_ALU);
      check_ext(8'ha0 + 8'(i), SRC_LD);
    end
  endtask

  task automatic test_flush();
    phys_tag_t rd;
    int cnt;
    int n;
    for (int i = 0; i < `RS_DEPTH - 1; i++) begin
      dispatch_op(32'h4000 + 32'(4 * i), next_tag(), 8'hc4, 1'b0, 8'h09, 1'b1);
    end
    rd  = next_tag();
    cnt = issue_count;
    n   = 0;
    expect_op(32'h4080, rd);
    dispatch_op(32'h4080, rd, 8'h0a, 1'b1, 8'h0b, 1'b1);
    while (issue_count == cnt && n < 20) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (n >= 20) fail_msg("ready op did not issue before the flush");
    // Refill the freed entry so the station is full while the op is in flight.
    dispatch_op(32'h4084, next_tag(), 8'hc4, 1'b0, 8'h0c, 1'b1);
    if (rs_full !== 1'b1) fail_msg("rs_full is not set before the flush");
    // The issued op is now inside the pipeline.
    flush = 1'b1;
    exp_rd_q.delete();
    exp_pc_q.delete();
    exp_mul_q.delete();
    @(posedge clk);
    #2;
    flush = 1'b0;
    if (rs_full !== 1'b0) fail_msg("rs_full is set after flush");
    cnt = issue_count;
    alu_send(8'hc4);
    idle(12);
    if (issue_count != cnt) fail_msg("a flushed entry issued");
  endtask

  initial begin
    rst_n = 1'b0;
    flush = 1'b0;
    dispatch_valid = 1'b0;
    dispatch_pc = '0;
    dispatch_rd = '0;
    dispatch_src1 = '0;
    dispatch_src2 = '0;
    src1_ready = 1'b0;
    src2_ready = 1'b0;
    alu_req = 1'b0;
    alu_tag = '0;
    ld_req = 1'b0;
    ld_tag = '0;
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
    test_ready_order();
    test_wakeup();
    test_bypass();
    test_full();
    test_round_robin();
    test_flush();
    test_ready_order();
    $display("Run done: %0d errors, %0d issues, %0d broadcasts", errors, issue_count, bcast_count);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(NUM_TESTS * 200 * 40);
    $display("Watchdog expired before the tests finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+common
common/ooo_types_pkg.sv
common/cdb_pkg.sv
rs_mul/rs_mul_station.sv
rs_mul/mul_pipe.sv
hdl/cdb_arbiter.sv
hdl/mul_cluster_top.sv
tb/mul_cluster_chk.sv
tb/mul_cluster_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module mul_cluster_tb

out=$(./obj_dir/Vmul_cluster_tb)
echo "$out"

if echo "$out" | grep -q "TEST RESULT: PASS"; then
  exit 0
else
  exit 1
fi
